//--- Bender.yml
package:
  name: afu

export_include_dirs:
  - source

sources:
  - source/ccip_if_pkg.sv
  - source/ccip_avmm_pkg.sv
  - source/ccip_fifo.sv
  - source/ccip_avmm_mmio.sv
  - source/avmm_ccip_host_rd.sv
  - source/avmm_ccip_host_wr.sv
  - source/dma_copy_engine.sv
  - source/afu.sv
  - target: test
    files:
      - test/host_mem_model.sv
      - test/afu_tb.sv

//--- afu.f
+incdir+source
source/ccip_if_pkg.sv
source/ccip_avmm_pkg.sv
source/ccip_fifo.sv
source/ccip_avmm_mmio.sv
source/avmm_ccip_host_rd.sv
source/avmm_ccip_host_wr.sv
source/dma_copy_engine.sv
source/afu.sv
test/host_mem_model.sv
test/afu_tb.sv

//--- source/afu.sv
// top level on the single host clock; host must return reads in order
`include "afu_settings.svh"

module afu (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    c0_rx_rd_valid,
	input  ccip_if_pkg::t_tag       c0_rx_rd_tag,
	input  ccip_if_pkg::t_line_data c0_rx_rd_data,
	input  logic                    c0_rx_mmio_wr,
	input  logic                    c0_rx_mmio_rd,
	input  ccip_if_pkg::t_mmio_addr c0_rx_mmio_addr,
	input  ccip_if_pkg::t_tid       c0_rx_mmio_tid,
	input  ccip_if_pkg::t_line_data c0_rx_mmio_data,
	input  logic                    c0_tx_alm_full,
	input  logic                    c1_tx_alm_full,
	output logic                    c0_tx_valid,
	output ccip_if_pkg::t_line_addr c0_tx_addr,
	output ccip_if_pkg::t_tag       c0_tx_tag,
	output logic                    c1_tx_valid,
	output ccip_if_pkg::t_line_addr c1_tx_addr,
	output ccip_if_pkg::t_line_data c1_tx_data,
	output logic                    c1_tx_intr,
	output logic                    c2_tx_valid,
	output ccip_if_pkg::t_tid       c2_tx_tid,
	output ccip_if_pkg::t_line_data c2_tx_data
);

	// ********************
	// mmio_avmm link
	// ********************
	logic                        mmio_read;
	logic                        mmio_write;
	logic [`AFU_MMIO_ADDR_W+1:0] mmio_address;
	ccip_if_pkg::t_line_data     mmio_writedata;
	ccip_if_pkg::t_line_data     mmio_readdata;
	logic                        mmio_readdatavalid;
	logic                        mmio_waitrequest;

	// ********************
	// rd_avmm and wr_avmm links
	// ********************
	logic                      rd_read;
	ccip_avmm_pkg::t_byte_addr rd_address;
	ccip_avmm_pkg::t_burst     rd_burstcount;
	logic                      rd_waitrequest;
	logic                      rd_readdatavalid;
	ccip_if_pkg::t_line_data   rd_readdata;
	logic                      wr_write;
	ccip_avmm_pkg::t_byte_addr wr_address;
	ccip_avmm_pkg::t_burst     wr_burstcount;
	ccip_if_pkg::t_line_data   wr_writedata;
	logic                      wr_waitrequest;
	logic                      dma_irq;

	ccip_avmm_mmio mmio_i (
		.clk, .rst_n,
		.c0_rx_mmio_wr, .c0_rx_mmio_rd, .c0_rx_mmio_addr, .c0_rx_mmio_tid, .c0_rx_mmio_data,
		.c2_tx_valid, .c2_tx_tid, .c2_tx_data,
		.avmm_read          (mmio_read),
		.avmm_write         (mmio_write),
		.avmm_address       (mmio_address),
		.avmm_writedata     (mmio_writedata),
		.avmm_readdata      (mmio_readdata),
		.avmm_readdatavalid (mmio_readdatavalid),
		.avmm_waitrequest   (mmio_waitrequest)
	);

	avmm_ccip_host_rd host_rd_i (
		.clk, .rst_n,
		.avmm_read          (rd_read),
		.avmm_address       (rd_address),
		.avmm_burstcount    (rd_burstcount),
		.avmm_waitrequest   (rd_waitrequest),
		.avmm_readdatavalid (rd_readdatavalid),
		.avmm_readdata      (rd_readdata),
		.c0_tx_alm_full, .c0_tx_valid, .c0_tx_addr, .c0_tx_tag,
		.c0_rx_rd_valid, .c0_rx_rd_tag, .c0_rx_rd_data
	);

	avmm_ccip_host_wr host_wr_i (
		.clk, .rst_n,
		.avmm_write       (wr_write),
		.avmm_address     (wr_address),
		.avmm_burstcount  (wr_burstcount),
		.avmm_writedata   (wr_writedata),
		.avmm_waitrequest (wr_waitrequest),
		.irq              (dma_irq),
		.c1_tx_alm_full, .c1_tx_valid, .c1_tx_addr, .c1_tx_data, .c1_tx_intr
	);

	dma_copy_engine dma_i (
		.clk, .rst_n,
		.mmio_read, .mmio_write, .mmio_address, .mmio_writedata,
		.mmio_readdata, .mmio_readdatavalid, .mmio_waitrequest,
		.rd_read, .rd_address, .rd_burstcount, .rd_waitrequest, .rd_readdatavalid, .rd_readdata,
		.wr_write, .wr_address, .wr_burstcount, .wr_writedata, .wr_waitrequest,
		.dma_irq
	);

endmodule

//--- source/afu_settings.svh
// sizes shared by the whole unit; data is 64 bits and bursts stop at 4 words
`ifndef AFU_SETTINGS_SVH
`define AFU_SETTINGS_SVH

// ********************
// host channel fields
// ********************
`define AFU_DATA_W      64 // one line per beat
`define AFU_LINE_ADDR_W 32 // line address, byte address >> 3
`define AFU_TAG_W       4  // read tag, rotates in order
`define AFU_TID_W       9  // register transaction id
`define AFU_MMIO_ADDR_W 16 // register address in 32-bit units

// ********************
// buffering
// ********************
`define AFU_FIFO_DEPTH  8  // bridge buffer entries
`define AFU_MAX_BURST   4  // longest copy burst, in words

`endif

//--- source/avmm_ccip_host_rd.sv
// read bridge; the host must complete reads in request order
`include "afu_settings.svh"

module avmm_ccip_host_rd (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     avmm_read,
	input  ccip_avmm_pkg::t_byte_addr avmm_address,
	input  ccip_avmm_pkg::t_burst    avmm_burstcount,
	output logic                     avmm_waitrequest,
	output logic                     avmm_readdatavalid,
	output ccip_if_pkg::t_line_data  avmm_readdata,
	input  logic                     c0_tx_alm_full,
	output logic                     c0_tx_valid,
	output ccip_if_pkg::t_line_addr  c0_tx_addr,
	output ccip_if_pkg::t_tag        c0_tx_tag,
	input  logic                     c0_rx_rd_valid,
	input  ccip_if_pkg::t_tag        c0_rx_rd_tag,
	input  ccip_if_pkg::t_line_data  c0_rx_rd_data
);

	localparam int CNT_W = $clog2(`AFU_FIFO_DEPTH + 1);

	ccip_avmm_pkg::t_burst issue_left;  // lines of the burst not yet sent
	logic [CNT_W-1:0]      outstanding; // accepted, not yet completed
	logic [CNT_W-1:0]      buffered;
	logic [CNT_W:0]        credits;
	ccip_if_pkg::t_tag     exp_tag;
	ccip_if_pkg::t_rd_cpl  rx_cpl;
	ccip_if_pkg::t_rd_cpl  head_cpl;
	logic                  accept;
	logic                  empty;

	assign credits = outstanding + buffered;
	assign avmm_waitrequest = c0_tx_alm_full || (issue_left != '0) ||
		(credits > (`AFU_FIFO_DEPTH - `AFU_MAX_BURST)); // room for a full burst
	assign accept      = avmm_read && !avmm_waitrequest;
	assign c0_tx_valid = (issue_left != '0) && !c0_tx_alm_full; // never under alm full

	// ********************
	// burst expansion
	// ********************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issue_left  <= '0;
			outstanding <= '0;
			c0_tx_tag   <= '0;
			exp_tag     <= '0;
		end else begin
			if (accept)
				issue_left <= avmm_burstcount;
			else if (c0_tx_valid)
				issue_left <= issue_left - 3'd1;
			outstanding <= outstanding + CNT_W'(accept ? avmm_burstcount : 3'd0)
				- CNT_W'(c0_rx_rd_valid);
			if (c0_tx_valid)
				c0_tx_tag <= c0_tx_tag + 1'b1; // rotating tag
			if (c0_rx_rd_valid)
				exp_tag <= exp_tag + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			c0_tx_addr <= avmm_address[`AFU_LINE_ADDR_W+2:3]; // bytes to lines
		else if (c0_tx_valid)
			c0_tx_addr <= c0_tx_addr + 1'b1; // consecutive lines
	end

	// ********************
	// completion buffer
	// ********************
	assign rx_cpl = '{tag: c0_rx_rd_tag, data: c0_rx_rd_data};

	ccip_fifo #(
		.item_t (ccip_if_pkg::t_rd_cpl),
		.DEPTH  (`AFU_FIFO_DEPTH)
	) cpl_fifo_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (c0_rx_rd_valid),
		.push_data (rx_cpl),
		.pop       (avmm_readdatavalid),
		.pop_data  (head_cpl),
		.empty     (empty),
		.full      (),
		.count     (buffered)
	);

	assign avmm_readdatavalid = !empty; // drained every cycle
	assign avmm_readdata      = head_cpl.data;

	// host returns completions in request order
	a_tag_order : assert property (@(posedge clk) disable iff (!rst_n)
		c0_rx_rd_valid |-> c0_rx_rd_tag == exp_tag);

endmodule

//--- source/avmm_ccip_host_wr.sv
// write bridge; interrupt is queued behind all accepted writes, no write responses
`include "afu_settings.svh"

module avmm_ccip_host_wr (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      avmm_write,
	input  ccip_avmm_pkg::t_byte_addr avmm_address,
	input  ccip_avmm_pkg::t_burst     avmm_burstcount,
	input  ccip_if_pkg::t_line_data   avmm_writedata,
	output logic                      avmm_waitrequest,
	input  logic                      irq,
	input  logic                      c1_tx_alm_full,
	output logic                      c1_tx_valid,
	output ccip_if_pkg::t_line_addr   c1_tx_addr,
	output ccip_if_pkg::t_line_data   c1_tx_data,
	output logic                      c1_tx_intr
);

	ccip_avmm_pkg::t_burst   beats_left; // zero means next beat starts a burst
	ccip_if_pkg::t_line_addr next_addr;
	ccip_if_pkg::t_wr_req    push_req;
	ccip_if_pkg::t_wr_req    head_req;
	logic                    irq_pend;   // interrupt waiting for a slot
	logic                    beat;
	logic                    push;
	logic                    full;
	logic                    empty;

	assign avmm_waitrequest = full || irq_pend; // writes wait behind the interrupt
	assign beat = avmm_write && !avmm_waitrequest;
	assign push = beat || (irq_pend && !full);

	always_comb begin
		push_req.addr = (beats_left == '0) ? avmm_address[`AFU_LINE_ADDR_W+2:3] : next_addr;
		push_req.data = avmm_writedata;
		push_req.intr = !beat;
	end

	// ********************
	// burst and irq tracking
	// ********************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			beats_left <= '0;
			irq_pend   <= 1'b0;
		end else begin
			if (irq)
				irq_pend <= 1'b1;
			else if (push && !beat)
				irq_pend <= 1'b0; // interrupt entry queued
			if (beat)
				beats_left <= (beats_left == '0) ? avmm_burstcount - 3'd1 : beats_left - 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (beat)
			next_addr <= push_req.addr + 1'b1;
	end

	ccip_fifo #(
		.item_t (ccip_if_pkg::t_wr_req),
		.DEPTH  (`AFU_FIFO_DEPTH)
	) req_fifo_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (push),
		.push_data (push_req),
		.pop       (c1_tx_valid),
		.pop_data  (head_req),
		.empty     (empty),
		.full      (full),
		.count     ()
	);

	// ********************
	// channel 1
	// ********************
	assign c1_tx_valid = !empty && !c1_tx_alm_full;
	assign c1_tx_addr  = head_req.addr;
	assign c1_tx_data  = head_req.data;
	assign c1_tx_intr  = head_req.intr;

	// engine raises irq only once its last write is taken
	a_irq_alone : assert property (@(posedge clk) disable iff (!rst_n) irq |-> !beat);

endmodule

//--- source/ccip_avmm_mmio.sv
// register bridge; only one register read may be pending at a time
`include "afu_settings.svh"

module ccip_avmm_mmio (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         c0_rx_mmio_wr,
	input  logic                         c0_rx_mmio_rd,
	input  ccip_if_pkg::t_mmio_addr      c0_rx_mmio_addr,
	input  ccip_if_pkg::t_tid            c0_rx_mmio_tid,
	input  ccip_if_pkg::t_line_data      c0_rx_mmio_data,
	output logic                         c2_tx_valid,
	output ccip_if_pkg::t_tid            c2_tx_tid,
	output ccip_if_pkg::t_line_data      c2_tx_data,
	output logic                         avmm_read,
	output logic                         avmm_write,
	output logic [`AFU_MMIO_ADDR_W+1:0]  avmm_address,
	output ccip_if_pkg::t_line_data      avmm_writedata,
	input  ccip_if_pkg::t_line_data      avmm_readdata,
	input  logic                         avmm_readdatavalid,
	input  logic                         avmm_waitrequest
);

	ccip_if_pkg::t_tid pend_tid; // tid of the read in flight
	logic              rd_pend;

	// ********************
	// request side
	// ********************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			avmm_read  <= 1'b0;
			avmm_write <= 1'b0;
			rd_pend    <= 1'b0;
		end else begin
			avmm_read  <= c0_rx_mmio_rd | (avmm_read & avmm_waitrequest);  // hold until taken
			avmm_write <= c0_rx_mmio_wr | (avmm_write & avmm_waitrequest);
			if (c0_rx_mmio_rd)
				rd_pend <= 1'b1;
			else if (avmm_readdatavalid)
				rd_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (c0_rx_mmio_rd | c0_rx_mmio_wr) begin
			avmm_address   <= {c0_rx_mmio_addr, 2'b00}; // dword units to bytes
			avmm_writedata <= c0_rx_mmio_data;
		end
		if (c0_rx_mmio_rd)
			pend_tid <= c0_rx_mmio_tid;
	end

	// ********************
	// response on c2
	// ********************
	always_ff @(posedge clk) begin
		if (!rst_n)
			c2_tx_valid <= 1'b0;
		else
			c2_tx_valid <= avmm_readdatavalid; // one cycle after readdata
	end

	always_ff @(posedge clk) begin
		if (avmm_readdatavalid) begin
			c2_tx_tid  <= pend_tid;
			c2_tx_data <= avmm_readdata;
		end
	end

	// host must wait for c2 before the next read
	a_one_read : assert property (@(posedge clk) disable iff (!rst_n) c0_rx_mmio_rd |-> !rd_pend);

endmodule

//--- source/ccip_avmm_pkg.sv
// memory-mapped side types; byte addresses are line aligned
`include "afu_settings.svh"

package ccip_avmm_pkg;

	typedef logic [`AFU_LINE_ADDR_W+2:0] t_byte_addr; // line address << 3
	typedef logic [2:0]                  t_burst;     // 1 to AFU_MAX_BURST

	// engine registers, 64 bits each, byte offset = index * 8
	typedef enum logic [2:0] {
		SRC    = 3'd0,
		DST    = 3'd1,
		LEN    = 3'd2, // word count
		CTRL   = 3'd3, // bit 0 start, reads zero
		STATUS = 3'd4
	} t_reg_idx;

	typedef struct packed {
		logic busy;
		logic done; // bit 0 of STATUS
	} t_dma_status;

endpackage

//--- source/ccip_fifo.sv
// payload-typed FIFO; push when full and pop when empty are not allowed
module ccip_fifo #(
	parameter type item_t = logic,
	parameter int  DEPTH  = 8
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         push,
	input  item_t                        push_data,
	input  logic                         pop,
	output item_t                        pop_data,
	output logic                         empty,
	output logic                         full,
	output logic [$clog2(DEPTH+1)-1:0]   count
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	item_t            mem [DEPTH]; // storage, no reset
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	assign empty    = (count == '0);
	assign full     = (count == CNT_W'(DEPTH));
	assign pop_data = mem[rd_ptr]; // head shows through

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	// ********************
	// checks
	// ********************
	a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
	a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

//--- source/ccip_if_pkg.sv
// host channel field types; widths come from afu_settings.svh
`include "afu_settings.svh"

package ccip_if_pkg;

	// ********************
	// single fields
	// ********************
	typedef logic [`AFU_LINE_ADDR_W-1:0] t_line_addr; // line granular
	typedef logic [`AFU_DATA_W-1:0]      t_line_data;
	typedef logic [`AFU_TAG_W-1:0]       t_tag;
	typedef logic [`AFU_MMIO_ADDR_W-1:0] t_mmio_addr; // 32-bit units
	typedef logic [`AFU_TID_W-1:0]       t_tid;

	// ********************
	// buffer payloads
	// ********************
	typedef struct packed {
		t_tag       tag;  // kept for debug, order already checked
		t_line_data data;
	} t_rd_cpl;

	typedef struct packed {
		t_line_addr addr;
		t_line_data data;
		logic       intr; // entry is an interrupt, addr and data unused
	} t_wr_req;

endpackage

//--- source/dma_copy_engine.sv
// copy engine; addresses must be line aligned and source and destination must not overlap
`include "afu_settings.svh"

module dma_copy_engine (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        mmio_read,
	input  logic                        mmio_write,
	input  logic [`AFU_MMIO_ADDR_W+1:0] mmio_address,
	input  ccip_if_pkg::t_line_data     mmio_writedata,
	output ccip_if_pkg::t_line_data     mmio_readdata,
	output logic                        mmio_readdatavalid,
	output logic                        mmio_waitrequest,
	output logic                        rd_read,
	output ccip_avmm_pkg::t_byte_addr   rd_address,
	output ccip_avmm_pkg::t_burst       rd_burstcount,
	input  logic                        rd_waitrequest,
	input  logic                        rd_readdatavalid,
	input  ccip_if_pkg::t_line_data     rd_readdata,
	output logic                        wr_write,
	output ccip_avmm_pkg::t_byte_addr   wr_address,
	output ccip_avmm_pkg::t_burst       wr_burstcount,
	output ccip_if_pkg::t_line_data     wr_writedata,
	input  logic                        wr_waitrequest,
	output logic                        dma_irq
);

	localparam int IDX_W = $clog2(`AFU_MAX_BURST);

	typedef enum logic [1:0] {IDLE, RD_REQ, XFER} state_t;

	state_t                     state;
	ccip_avmm_pkg::t_reg_idx    reg_idx;
	ccip_avmm_pkg::t_byte_addr  src;
	ccip_avmm_pkg::t_byte_addr  dst;
	logic [31:0]                len;
	ccip_avmm_pkg::t_dma_status status;
	ccip_avmm_pkg::t_byte_addr  rd_addr;    // next read burst
	ccip_avmm_pkg::t_byte_addr  wr_addr;    // current write burst
	logic [31:0]                words_left; // not yet requested
	ccip_avmm_pkg::t_burst      burst_len;
	ccip_avmm_pkg::t_burst      rx_cnt;     // words returned this burst
	ccip_avmm_pkg::t_burst      wr_cnt;     // words written this burst
	ccip_if_pkg::t_line_data    word_buf [`AFU_MAX_BURST];
	logic                       start;
	logic                       wr_take;

	assign reg_idx          = ccip_avmm_pkg::t_reg_idx'(mmio_address[5:3]); // 64-bit regs
	assign mmio_waitrequest = 1'b0;
	assign start = mmio_write && (reg_idx == ccip_avmm_pkg::CTRL) && mmio_writedata[0];

	// ********************
	// register readback
	// ********************
	always_ff @(posedge clk) begin
		case (reg_idx)
			ccip_avmm_pkg::SRC:    mmio_readdata <= `AFU_DATA_W'(src);
			ccip_avmm_pkg::DST:    mmio_readdata <= `AFU_DATA_W'(dst);
			ccip_avmm_pkg::LEN:    mmio_readdata <= `AFU_DATA_W'(len);
			ccip_avmm_pkg::STATUS: mmio_readdata <= `AFU_DATA_W'(status);
			default:               mmio_readdata <= '0; // CTRL and holes
		endcase
	end

	// ********************
	// master outputs
	// ********************
	assign rd_read       = (state == RD_REQ);
	assign rd_address    = rd_addr;
	assign rd_burstcount = (words_left > `AFU_MAX_BURST) ?
		ccip_avmm_pkg::t_burst'(`AFU_MAX_BURST) : ccip_avmm_pkg::t_burst'(words_left);
	assign wr_write      = (state == XFER) && (wr_cnt != rx_cnt); // a word is waiting
	assign wr_address    = wr_addr; // first word of the burst
	assign wr_burstcount = burst_len;
	assign wr_writedata  = word_buf[wr_cnt[IDX_W-1:0]];
	assign wr_take       = wr_write && !wr_waitrequest;

	always_ff @(posedge clk) begin
		if (rd_readdatavalid)
			word_buf[rx_cnt[IDX_W-1:0]] <= rd_readdata;
	end

	// ********************
	// registers and sequencer
	// ********************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state              <= IDLE;
			src                <= '0;
			dst                <= '0;
			len                <= '0;
			status             <= '0;
			dma_irq            <= 1'b0;
			mmio_readdatavalid <= 1'b0;
			rx_cnt             <= '0;
			wr_cnt             <= '0;
		end else begin
			dma_irq            <= 1'b0; // pulse
			mmio_readdatavalid <= mmio_read;
			if (mmio_write) begin
				case (reg_idx)
					ccip_avmm_pkg::SRC: src <= ccip_avmm_pkg::t_byte_addr'(mmio_writedata);
					ccip_avmm_pkg::DST: dst <= ccip_avmm_pkg::t_byte_addr'(mmio_writedata);
					ccip_avmm_pkg::LEN: len <= mmio_writedata[31:0];
					default: ;
				endcase
			end
			case (state)
				IDLE: begin
					if (start && len == '0) begin
						status <= '{busy: 1'b0, done: 1'b1}; // nothing to copy
						dma_irq <= 1'b1;
					end else if (start) begin
						status     <= '{busy: 1'b1, done: 1'b0};
						rd_addr    <= src;
						wr_addr    <= dst;
						words_left <= len;
						state      <= RD_REQ;
					end
				end
				RD_REQ: begin
					if (!rd_waitrequest) begin
						burst_len  <= rd_burstcount;
						words_left <= words_left - rd_burstcount;
						rd_addr    <= rd_addr + {rd_burstcount, 3'b000};
						rx_cnt     <= '0;
						wr_cnt     <= '0;
						state      <= XFER;
					end
				end
				XFER: begin
					if (rd_readdatavalid)
						rx_cnt <= rx_cnt + 3'd1;
					if (wr_take) begin
						wr_cnt <= wr_cnt + 3'd1;
						if (wr_cnt == burst_len - 3'd1) begin // burst fully written
							wr_addr <= wr_addr + {burst_len, 3'b000};
							if (words_left == '0) begin
								status  <= '{busy: 1'b0, done: 1'b1};
								dma_irq <= 1'b1;
								state   <= IDLE;
							end else begin
								state <= RD_REQ;
							end
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- test/afu_tb.sv
// copy unit testbench; host reads return in order and stimulus comes from seed 72
module afu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int SEED    = 72;
	localparam int N_JOBS  = 12;
	localparam int TIMEOUT = 3000; // cycles per wait

	logic                    clk;
	logic                    rst_n;
	logic                    bp_en;
	logic                    c0_rx_rd_valid;
	ccip_if_pkg::t_tag       c0_rx_rd_tag;
	ccip_if_pkg::t_line_data c0_rx_rd_data;
	logic                    c0_rx_mmio_wr;
	logic                    c0_rx_mmio_rd;
	ccip_if_pkg::t_mmio_addr c0_rx_mmio_addr;
	ccip_if_pkg::t_tid       c0_rx_mmio_tid;
	ccip_if_pkg::t_line_data c0_rx_mmio_data;
	logic                    c0_tx_alm_full;
	logic                    c1_tx_alm_full;
	logic                    c0_tx_valid;
	ccip_if_pkg::t_line_addr c0_tx_addr;
	ccip_if_pkg::t_tag       c0_tx_tag;
	logic                    c1_tx_valid;
	ccip_if_pkg::t_line_addr c1_tx_addr;
	ccip_if_pkg::t_line_data c1_tx_data;
	logic                    c1_tx_intr;
	logic                    c2_tx_valid;
	ccip_if_pkg::t_tid       c2_tx_tid;
	ccip_if_pkg::t_line_data c2_tx_data;

	int                      mismatches;
	int                      protocol_errs;
	int                      timeouts;
	ccip_if_pkg::t_line_data ref_mem [ccip_if_pkg::t_line_addr]; // reference image
	ccip_if_pkg::t_tag       exp_tag; // next read tag in issue order

	always #4 clk = ~clk; // 8 ns

	afu dut_i (.*);
	host_mem_model host_i (.*);

	// ********************
	// compare tasks
	// ********************
	task automatic check_line(input ccip_if_pkg::t_line_addr addr,
			input ccip_if_pkg::t_line_data got, input ccip_if_pkg::t_line_data exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH %0t host_mem[%h] got %h expected %h", $time, addr, got, exp);
		end
	endtask

	task automatic check_reg(input string name,
			input ccip_if_pkg::t_line_data got, input ccip_if_pkg::t_line_data exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_status(input ccip_avmm_pkg::t_dma_status got,
			input ccip_avmm_pkg::t_dma_status exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH %0t STATUS got busy=%b done=%b expected busy=%b done=%b",
				$time, got.busy, got.done, exp.busy, exp.done);
		end
	endtask

	task automatic check_tid(input ccip_if_pkg::t_tid got, input ccip_if_pkg::t_tid exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH %0t c2_tx_tid got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_tag(input ccip_if_pkg::t_tag got, input ccip_if_pkg::t_tag exp);
		if (got !== exp) begin
			mismatches++;
			$display("MISMATCH %0t c0_tx_tag got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic report_error(input string msg);
		protocol_errs++;
		$display("%0t: %s", $time, msg);
	endtask

	// tags rotate from zero in issue order
	always @(negedge clk) begin
		if (!rst_n) begin
			exp_tag = '0;
		end else if (c0_tx_valid) begin
			check_tag(c0_tx_tag, exp_tag);
			exp_tag = exp_tag + 1'b1;
		end
	end

	// ********************
	// register access
	// ********************
	task automatic reg_write(input ccip_avmm_pkg::t_reg_idx idx, input ccip_if_pkg::t_line_data data);
		@(posedge clk);
		c0_rx_mmio_wr   <= 1'b1;
		c0_rx_mmio_addr <= ccip_if_pkg::t_mmio_addr'(int'(idx) * 2); // 64-bit regs in dwords
		c0_rx_mmio_data <= data;
		@(posedge clk);
		c0_rx_mmio_wr <= 1'b0;
	endtask

	task automatic reg_read(input ccip_avmm_pkg::t_reg_idx idx, output ccip_if_pkg::t_line_data data);
		ccip_if_pkg::t_tid tid;
		int                n;
		tid = ccip_if_pkg::t_tid'($urandom);
		@(posedge clk);
		c0_rx_mmio_rd   <= 1'b1;
		c0_rx_mmio_addr <= ccip_if_pkg::t_mmio_addr'(int'(idx) * 2);
		c0_rx_mmio_tid  <= tid;
		@(posedge clk);
		c0_rx_mmio_rd <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++; // cycles since the request cycle
		end while (!c2_tx_valid && n < TIMEOUT);
		if (!c2_tx_valid) begin
			timeouts++;
			$display("%0t: no response to the read of register %s", $time, idx.name());
			data = 'x;
		end else begin
			if (n != 3)
				report_error($sformatf("read response after %0d cycles instead of 3", n));
			check_tid(c2_tx_tid, tid);
			data = c2_tx_data;
		end
	endtask

	// ********************
	// behaviors
	// ********************
	task automatic readback_test();
		ccip_avmm_pkg::t_reg_idx regs [3];
		ccip_if_pkg::t_line_data val;
		ccip_if_pkg::t_line_data rd;
		regs = '{ccip_avmm_pkg::SRC, ccip_avmm_pkg::DST, ccip_avmm_pkg::LEN};
		for (int r = 0; r < 9; r++) begin
			if (regs[r % 3] == ccip_avmm_pkg::LEN)
				val = 64'($urandom); // 32-bit count
			else
				val = {$urandom, $urandom} & 64'h7_ffff_ffff; // 35-bit byte address
			reg_write(regs[r % 3], val);
			reg_read(regs[r % 3], rd);
			check_reg(regs[r % 3].name(), rd, val);
		end
	endtask

	task automatic run_job(input int job);
		ccip_if_pkg::t_line_addr src;
		ccip_if_pkg::t_line_addr dst;
		ccip_if_pkg::t_line_data word;
		ccip_if_pkg::t_line_data rd;
		int                      len;
		int                      wr0;
		int                      irq0;
		int                      n;
		len = (job == 1) ? 0 : $urandom_range(0, 20);
		src = ccip_if_pkg::t_line_addr'($urandom_range(0, 'hfff) * 32 + 'h1_0000);
		dst = src + 'h4_0000 + $urandom_range(0, 'hff); // far apart so the blocks never overlap
		for (int i = 0; i < len; i++) begin
			word = {$urandom, $urandom};
			host_i.poke(src + i, word);
			ref_mem[src + i] = word;
		end
		wr0  = host_i.wr_count;
		irq0 = host_i.irq_count;
		reg_write(ccip_avmm_pkg::SRC, ccip_if_pkg::t_line_data'({src, 3'b000}));
		reg_write(ccip_avmm_pkg::DST, ccip_if_pkg::t_line_data'({dst, 3'b000}));
		reg_write(ccip_avmm_pkg::LEN, ccip_if_pkg::t_line_data'(len));
		reg_write(ccip_avmm_pkg::CTRL, 64'd1);
		if (len >= 8)
			reg_write(ccip_avmm_pkg::CTRL, 64'd1); // engine still busy here
		n = 0;
		while (host_i.irq_count == irq0 && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (host_i.irq_count == irq0) begin
			timeouts++;
			$display("%0t: job %0d of %0d words never raised its interrupt", $time, job, len);
			return;
		end
		repeat (40) @(posedge clk); // window for stray writes or a second interrupt
		if (host_i.irq_count - irq0 != 1)
			report_error($sformatf("job %0d gave %0d interrupts", job, host_i.irq_count - irq0));
		if (host_i.wr_at_irq - wr0 != len)
			report_error($sformatf("job %0d interrupt came after %0d of %0d writes",
				job, host_i.wr_at_irq - wr0, len));
		if (host_i.wr_count != host_i.wr_at_irq)
			report_error($sformatf("job %0d wrote after its interrupt", job));
		reg_read(ccip_avmm_pkg::STATUS, rd);
		check_status(ccip_avmm_pkg::t_dma_status'(rd[1:0]), '{busy: 1'b0, done: 1'b1});
		@(posedge clk);
		for (int i = 0; i < len; i++) begin
			ref_mem[dst + i] = ref_mem[src + i]; // reference copy
			check_line(dst + i, host_i.peek(dst + i), ref_mem[dst + i]);
		end
	endtask

	// ********************
	// main sequence
	// ********************
	initial begin
		ccip_if_pkg::t_line_data rd;
		void'($urandom(SEED));
		clk             = 1'b0;
		rst_n           = 1'b0;
		bp_en           = 1'b0;
		c0_rx_mmio_wr   = 1'b0;
		c0_rx_mmio_rd   = 1'b0;
		c0_rx_mmio_addr = '0;
		c0_rx_mmio_tid  = '0;
		c0_rx_mmio_data = '0;
		mismatches      = 0;
		protocol_errs   = 0;
		timeouts        = 0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		if (c0_tx_valid !== 1'b0 || c1_tx_valid !== 1'b0 || c2_tx_valid !== 1'b0)
			report_error("a tx valid is not low right after reset");
		reg_read(ccip_avmm_pkg::STATUS, rd);
		check_reg("STATUS", rd, '0);
		readback_test();
		bp_en <= 1'b1; // random almost-full from here on
		for (int j = 0; j < N_JOBS; j++) begin
			if (timeouts == 0)
				run_job(j);
		end
		bp_en <= 1'b0;
		@(posedge clk);
		protocol_errs += host_i.bp_errors;
		$display("errors: %0d mismatches, %0d protocol, %0d timeouts",
			mismatches, protocol_errs, timeouts);
		if (mismatches == 0 && protocol_errs == 0 && timeouts == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- test/host_mem_model.sv
// host side model; reads come back in request order after 1 to 6 cycles, memory is sparse
module host_mem_model (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    bp_en,          // random almost-full on
	input  logic                    c0_tx_valid,
	input  ccip_if_pkg::t_line_addr c0_tx_addr,
	input  ccip_if_pkg::t_tag       c0_tx_tag,
	output logic                    c0_rx_rd_valid,
	output ccip_if_pkg::t_tag       c0_rx_rd_tag,
	output ccip_if_pkg::t_line_data c0_rx_rd_data,
	output logic                    c0_tx_alm_full,
	input  logic                    c1_tx_valid,
	input  ccip_if_pkg::t_line_addr c1_tx_addr,
	input  ccip_if_pkg::t_line_data c1_tx_data,
	input  logic                    c1_tx_intr,
	output logic                    c1_tx_alm_full
);
	timeunit 1ns;
	timeprecision 1ps;

	ccip_if_pkg::t_line_data mem [ccip_if_pkg::t_line_addr]; // sparse host memory
	ccip_if_pkg::t_line_addr rd_addr_q [$];
	ccip_if_pkg::t_tag       rd_tag_q [$];
	int unsigned             rd_due_q [$];  // cycle the completion may go out
	int unsigned             cycle;
	int                      wr_count;
	int                      irq_count;
	int                      wr_at_irq;     // writes seen when the last interrupt came
	int                      bp_errors;

	function automatic void poke(input ccip_if_pkg::t_line_addr a, input ccip_if_pkg::t_line_data d);
		mem[a] = d;
	endfunction

	function automatic ccip_if_pkg::t_line_data peek(input ccip_if_pkg::t_line_addr a);
		if (mem.exists(a))
			return mem[a];
		return {~a, a}; // fill pattern over the whole address
	endfunction

	initial begin
		c0_rx_rd_valid = 1'b0;
		c0_rx_rd_tag   = '0;
		c0_rx_rd_data  = '0;
		c0_tx_alm_full = 1'b0;
		c1_tx_alm_full = 1'b0;
		cycle          = 0;
		wr_count       = 0;
		irq_count      = 0;
		wr_at_irq      = 0;
		bp_errors      = 0;
	end

	// ********************
	// monitor, mid cycle
	// ********************
	always @(negedge clk) begin
		if (rst_n) begin
			if (c0_tx_valid && c0_tx_alm_full) begin
				bp_errors++;
				$display("%0t: read request sent while c0_tx_alm_full was high", $time);
			end
			if (c1_tx_valid && c1_tx_alm_full) begin
				bp_errors++;
				$display("%0t: write request sent while c1_tx_alm_full was high", $time);
			end
			if (c0_tx_valid) begin
				rd_addr_q.push_back(c0_tx_addr);
				rd_tag_q.push_back(c0_tx_tag);
				rd_due_q.push_back(cycle + $urandom_range(1, 6)); // host latency
			end
			if (c1_tx_valid && c1_tx_intr) begin
				irq_count++;
				wr_at_irq = wr_count;
			end else if (c1_tx_valid) begin
				mem[c1_tx_addr] = c1_tx_data;
				wr_count++;
			end
		end
	end

	// ********************
	// drive, rising edge
	// ********************
	always @(posedge clk) begin
		cycle++;
		if (!rst_n) begin
			c0_rx_rd_valid <= 1'b0;
			c0_tx_alm_full <= 1'b0;
			c1_tx_alm_full <= 1'b0;
		end else begin
			c0_tx_alm_full <= bp_en && ($urandom_range(0, 3) == 0); // about one cycle in four
			c1_tx_alm_full <= bp_en && ($urandom_range(0, 3) == 0);
			if (rd_due_q.size() != 0 && cycle >= rd_due_q[0]) begin // oldest first
				c0_rx_rd_valid <= 1'b1;
				c0_rx_rd_tag   <= rd_tag_q.pop_front();
				c0_rx_rd_data  <= peek(rd_addr_q.pop_front());
				void'(rd_due_q.pop_front());
			end else begin
				c0_rx_rd_valid <= 1'b0;
			end
		end
	end

endmodule
